/* src/sl_ctrl_pkg.sv */
// core control types shared by the support logic trackers and the top level
package sl_ctrl_pkg;

  // --------------------
  // controller pc select
  // --------------------
  // encoding of the pc mux select driven by the controller FSM
  typedef enum logic [3:0] {
    PC_BOOT     = 4'b0000,
    PC_JUMP     = 4'b0010,
    PC_BRANCH   = 4'b0011,
    PC_MRET     = 4'b0101,
    PC_DRET     = 4'b0111,
    PC_TRAP_EXC = 4'b1000,
    PC_TRAP_IRQ = 4'b1001,
    PC_TRAP_DBD = 4'b1010,
    PC_TRAP_DBE = 4'b1011
  } pc_mux_e;

  // retires a debug request stays recorded when seen without a retire
  localparam int DBG_REQ_HOLD_C = 2;

endpackage : sl_ctrl_pkg

/* src/sl_obi_pkg.sv */
// OBI monitor types and default sizes for the bus support logic
package sl_obi_pkg;

  // --------------------
  // phase monitor state
  // --------------------
  // idle covers both "no request" and "request granted this cycle"
  typedef enum logic {
    OBI_IDLE      = 1'b0,
    OBI_ADDR_WAIT = 1'b1
  } obi_phase_e;

  // width of the address phase counter
  localparam int OBI_CNT_W_C = 8;

  // max outstanding requests tracked per attribute
  localparam int ATTR_FIFO_DEPTH_C = 4;

endpackage : sl_obi_pkg

/* src/sl_obi_phases_monitor.sv */
// OBI phase monitor: address and response phase continuation and grant count
`timescale 1ns/10ps

module sl_obi_phases_monitor
  import sl_obi_pkg::*;
#(
  parameter int CNT_W = OBI_CNT_W_C
) (
  input  logic             in_support_if,
  input  logic             reset_i,
  input  logic             obi_req_i,
  input  logic             obi_gnt_i,
  input  logic             obi_rvalid_i,
  output logic             addr_ph_cont_o,
  output logic             resp_ph_cont_o,
  output logic [CNT_W-1:0] v_addr_ph_cnt_o
);

  obi_phase_e       state_q;
  logic [CNT_W-1:0] outstanding_q;
  logic [CNT_W-1:0] addr_cnt_q;
  logic             addr_done;

  // address phase completes on req and gnt together
  assign addr_done = obi_req_i && obi_gnt_i;

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      state_q       <= OBI_IDLE;
      outstanding_q <= '0;
      addr_cnt_q    <= '0;
    end else begin
      // stalled request moves to wait, anything else back to idle
      state_q <= (obi_req_i && !obi_gnt_i) ? OBI_ADDR_WAIT : OBI_IDLE;
      // grants in, responses out
      case ({addr_done, obi_rvalid_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
      // wraps at CNT_W bits
      if (addr_done) begin
        addr_cnt_q <= addr_cnt_q + 1'b1;
      end
    end
  end

  assign addr_ph_cont_o  = obi_req_i && (state_q == OBI_ADDR_WAIT);
  assign resp_ph_cont_o  = (outstanding_q != '0) && !obi_rvalid_i;
  assign v_addr_ph_cnt_o = addr_cnt_q;

  // --------------------
  // protocol checks
  // --------------------
  // response needs an earlier grant
  a_rvalid_has_req: assert property (@(posedge in_support_if) disable iff (reset_i)
    obi_rvalid_i |-> (outstanding_q != '0));

  // stalled request must stay up until granted
  a_req_held_in_stall: assert property (@(posedge in_support_if) disable iff (reset_i)
    (obi_req_i && !obi_gnt_i) |=> obi_req_i);

endmodule : sl_obi_phases_monitor

/* src/sl_req_attribute_fifo.sv */
// request attribute FIFO: pairs each OBI response with its request's attribute
`timescale 1ns/10ps

module sl_req_attribute_fifo
  import sl_obi_pkg::*;
#(
  parameter int ATTR_WIDTH = 1,
  parameter int DEPTH      = ATTR_FIFO_DEPTH_C
) (
  input  logic                  in_support_if,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  logic                  gnt_i,
  input  logic                  rvalid_i,
  input  logic [ATTR_WIDTH-1:0] attr_i,
  output logic [ATTR_WIDTH-1:0] attr_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OCC_W = $clog2(DEPTH + 1);

  logic [ATTR_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [OCC_W-1:0]      count_q;
  logic                  push;
  logic                  pop;
  logic                  empty;
  logic                  full;

  assign empty = (count_q == '0);
  assign full  = (count_q == OCC_W'(DEPTH));
  // push at address phase completion, pop with the response
  assign push  = req_i && gnt_i;
  assign pop   = rvalid_i && !empty;

  // storage only, no reset needed
  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem[wr_ptr_q] <= attr_i;
    end
  end

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // oldest entry is shown while it waits, zero when nothing is outstanding
  assign attr_o = empty ? '0 : mem[rd_ptr_q];

  a_no_push_full: assert property (@(posedge in_support_if) disable iff (reset_i)
    (push && full) |-> pop);

  a_no_rvalid_empty: assert property (@(posedge in_support_if) disable iff (reset_i)
    rvalid_i |-> !empty);

endmodule : sl_req_attribute_fifo

/* src/sl_gntpar_detector.sv */
// grant parity error detector, holding an error across a stalled address phase
`timescale 1ns/10ps

module sl_gntpar_detector (
  input  logic in_support_if,
  input  logic reset_i,
  input  logic req_i,
  input  logic gnt_i,
  input  logic gntpar_i,
  output logic error_o
);

  logic prev_err_q;

  // gntpar should be the inverse of gnt
  // an error from an earlier stall cycle still counts
  assign error_o = req_i && ((gnt_i == gntpar_i) || prev_err_q);

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      prev_err_q <= 1'b0;
    end else if (req_i && !gnt_i) begin
      // stall, keep whatever was seen so far
      prev_err_q <= error_o;
    end else begin
      prev_err_q <= 1'b0;
    end
  end

endmodule : sl_gntpar_detector

/* src/sl_exception_tracker.sv */
// exception tracker: flags a data request issued after a trap was taken
`timescale 1ns/10ps

module sl_exception_tracker
  import sl_ctrl_pkg::*;
(
  input  logic    in_support_if,
  input  logic    reset_i,
  input  logic    pc_set_i,
  input  pc_mux_e pc_mux_i,
  input  logic    rvfi_valid_i,
  input  logic    data_req_i,
  input  logic    data_gnt_i,
  output logic    req_after_exception_o
);

  logic data_gnt_q;
  logic exception_active_q;
  logic req_after_exc_q;
  logic trap_taken;
  logic req_after_gnt;

  // trap in wb, exception or debug-entry-on-exception
  assign trap_taken    = pc_set_i && ((pc_mux_i == PC_TRAP_EXC) || (pc_mux_i == PC_TRAP_DBE));
  assign req_after_gnt = data_req_i && data_gnt_q;

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      data_gnt_q         <= 1'b0;
      exception_active_q <= 1'b0;
      req_after_exc_q    <= 1'b0;
    end else begin
      data_gnt_q <= data_gnt_i;
      if (trap_taken) begin
        exception_active_q <= 1'b1;
        if (req_after_gnt) begin
          req_after_exc_q <= 1'b1;
        end
      end else if (rvfi_valid_i) begin
        // retire ends the multi-op sequence
        exception_active_q <= 1'b0;
        req_after_exc_q    <= 1'b0;
      end else if (exception_active_q && req_after_gnt) begin
        req_after_exc_q <= 1'b1;
      end
    end
  end

  assign req_after_exception_o = req_after_exc_q;

endmodule : sl_exception_tracker

/* src/sl_debug_tracker.sv */
// debug tracker: first debug instruction, first fetch and recorded debug request
`timescale 1ns/10ps

module sl_debug_tracker
  import sl_ctrl_pkg::*;
(
  input  logic in_support_if,
  input  logic reset_i,
  input  logic rvfi_valid_i,
  input  logic rvfi_dbg_mode_i,
  input  logic rvfi_is_dret_i,
  input  logic rvfi_trap_i,
  input  logic debug_req_i,
  input  logic fetch_enable_i,
  output logic first_debug_ins_o,
  output logic first_fetch_o,
  output logic recorded_dbg_req_o
);

  localparam int HOLD_W = $clog2(DBG_REQ_HOLD_C + 1);

  logic              dbg_flag_q;
  logic              dret_pending_q;
  logic              fetch_seen_q;
  logic              recorded_q;
  logic [HOLD_W-1:0] hold_cnt_q;

  // --------------------
  // debug entry
  // --------------------
  assign first_debug_ins_o = rvfi_valid_i && rvfi_dbg_mode_i && !dbg_flag_q;

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      dbg_flag_q     <= 1'b0;
      dret_pending_q <= 1'b0;
    end else begin
      if (rvfi_valid_i) begin
        dbg_flag_q <= rvfi_dbg_mode_i;
        if (rvfi_is_dret_i && !rvfi_trap_i) begin
          dret_pending_q <= 1'b1;
        end
      end
      // dret retired last cycle, rearm the flag
      if (dret_pending_q) begin
        dbg_flag_q     <= 1'b0;
        dret_pending_q <= 1'b0;
      end
    end
  end

  // --------------------
  // core startup
  // --------------------
  assign first_fetch_o = fetch_enable_i && !fetch_seen_q;

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

  // --------------------
  // debug request record
  // --------------------
  // kept long enough that the core could have taken the request
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      recorded_q <= 1'b0;
      hold_cnt_q <= '0;
    end else if (debug_req_i) begin
      recorded_q <= 1'b1;
      hold_cnt_q <= rvfi_valid_i ? HOLD_W'(1) : HOLD_W'(DBG_REQ_HOLD_C);
    end else if (rvfi_valid_i) begin
      if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end else begin
        recorded_q <= 1'b0;
      end
    end
  end

  assign recorded_dbg_req_o = recorded_q;

endmodule : sl_debug_tracker

/* src/sl_support_logic.sv */
// support logic top: bus monitors, attribute FIFOs and core trackers
`timescale 1ns/10ps

module sl_support_logic
  import sl_ctrl_pkg::*;
  import sl_obi_pkg::*;
#(
  parameter int CNT_W           = OBI_CNT_W_C,
  parameter int ATTR_FIFO_DEPTH = ATTR_FIFO_DEPTH_C
) (
  input  logic             in_support_if,
  input  logic             reset_i,
  // instruction bus
  input  logic             instr_req_i,
  input  logic             instr_gnt_i,
  input  logic             instr_gntpar_i,
  input  logic             instr_rvalid_i,
  input  logic [31:0]      instr_req_pc_i,
  input  logic             instr_integrity_i,
  // data bus
  input  logic             data_req_i,
  input  logic             data_gnt_i,
  input  logic             data_gntpar_i,
  input  logic             data_rvalid_i,
  input  logic             data_req_is_store_i,
  input  logic             data_integrity_i,
  // controller and retirement
  input  logic             pc_set_i,
  input  pc_mux_e          pc_mux_i,
  input  logic             rvfi_valid_i,
  input  logic             rvfi_dbg_mode_i,
  input  logic             rvfi_is_dret_i,
  input  logic             rvfi_trap_i,
  input  logic             debug_req_i,
  input  logic             fetch_enable_i,
  // instruction bus results
  output logic             instr_addr_ph_cont_o,
  output logic             instr_resp_ph_cont_o,
  output logic [CNT_W-1:0] instr_v_addr_ph_cnt_o,
  output logic [31:0]      instr_resp_pc_o,
  output logic             instr_req_had_integrity_o,
  output logic             gntpar_error_in_response_instr_o,
  // data bus results
  output logic             data_addr_ph_cont_o,
  output logic             data_resp_ph_cont_o,
  output logic [CNT_W-1:0] data_v_addr_ph_cnt_o,
  output logic             req_was_store_o,
  output logic             data_req_had_integrity_o,
  output logic             gntpar_error_in_response_data_o,
  // tracker results
  output logic             req_after_exception_o,
  output logic             first_debug_ins_o,
  output logic             first_fetch_o,
  output logic             recorded_dbg_req_o
);

  logic instr_gntpar_err;
  logic data_gntpar_err;

  // --------------------
  // bus phase monitors
  // --------------------
  sl_obi_phases_monitor #(.CNT_W(CNT_W)) u_instr_phases (
    .in_support_if  (in_support_if),
    .reset_i        (reset_i),
    .obi_req_i      (instr_req_i),
    .obi_gnt_i      (instr_gnt_i),
    .obi_rvalid_i   (instr_rvalid_i),
    .addr_ph_cont_o (instr_addr_ph_cont_o),
    .resp_ph_cont_o (instr_resp_ph_cont_o),
    .v_addr_ph_cnt_o(instr_v_addr_ph_cnt_o)
  );

  sl_obi_phases_monitor #(.CNT_W(CNT_W)) u_data_phases (
    .in_support_if  (in_support_if),
    .reset_i        (reset_i),
    .obi_req_i      (data_req_i),
    .obi_gnt_i      (data_gnt_i),
    .obi_rvalid_i   (data_rvalid_i),
    .addr_ph_cont_o (data_addr_ph_cont_o),
    .resp_ph_cont_o (data_resp_ph_cont_o),
    .v_addr_ph_cnt_o(data_v_addr_ph_cnt_o)
  );

  // --------------------
  // grant parity
  // --------------------
  sl_gntpar_detector u_instr_gntpar (
    .in_support_if(in_support_if),
    .reset_i      (reset_i),
    .req_i        (instr_req_i),
    .gnt_i        (instr_gnt_i),
    .gntpar_i     (instr_gntpar_i),
    .error_o      (instr_gntpar_err)
  );

  sl_gntpar_detector u_data_gntpar (
    .in_support_if(in_support_if),
    .reset_i      (reset_i),
    .req_i        (data_req_i),
    .gnt_i        (data_gnt_i),
    .gntpar_i     (data_gntpar_i),
    .error_o      (data_gntpar_err)
  );

  // --------------------
  // response attributes
  // --------------------
  // instruction bus: fetch pc, integrity, gntpar error
  sl_req_attribute_fifo #(.ATTR_WIDTH(32), .DEPTH(ATTR_FIFO_DEPTH)) u_instr_pc_fifo (
    .in_support_if(in_support_if),
    .reset_i      (reset_i),
    .req_i        (instr_req_i),
    .gnt_i        (instr_gnt_i),
    .rvalid_i     (instr_rvalid_i),
    .attr_i       (instr_req_pc_i),
    .attr_o       (instr_resp_pc_o)
  );

  sl_req_attribute_fifo #(.ATTR_WIDTH(1), .DEPTH(ATTR_FIFO_DEPTH)) u_instr_integ_fifo (
    .in_support_if(in_support_if),
    .reset_i      (reset_i),
    .req_i        (instr_req_i),
    .gnt_i        (instr_gnt_i),
    .rvalid_i     (instr_rvalid_i),
    .attr_i       (instr_integrity_i),
    .attr_o       (instr_req_had_integrity_o)
  );

  sl_req_attribute_fifo #(.ATTR_WIDTH(1), .DEPTH(ATTR_FIFO_DEPTH)) u_instr_gntpar_fifo (
    .in_support_if(in_support_if),
    .reset_i      (reset_i),
    .req_i        (instr_req_i),
    .gnt_i        (instr_gnt_i),
    .rvalid_i     (instr_rvalid_i),
    .attr_i       (instr_gntpar_err),
    .attr_o       (gntpar_error_in_response_instr_o)
  );

  // data bus: store flag, integrity, gntpar error
  sl_req_attribute_fifo #(.ATTR_WIDTH(1), .DEPTH(ATTR_FIFO_DEPTH)) u_data_store_fifo (
    .in_support_if(in_support_if),
    .reset_i      (reset_i),
    .req_i        (data_req_i),
    .gnt_i        (data_gnt_i),
    .rvalid_i     (data_rvalid_i),
    .attr_i       (data_req_is_store_i),
    .attr_o       (req_was_store_o)
  );

  sl_req_attribute_fifo #(.ATTR_WIDTH(1), .DEPTH(ATTR_FIFO_DEPTH)) u_data_integ_fifo (
    .in_support_if(in_support_if),
    .reset_i      (reset_i),
    .req_i        (data_req_i),
    .gnt_i        (data_gnt_i),
    .rvalid_i     (data_rvalid_i),
    .attr_i       (data_integrity_i),
    .attr_o       (data_req_had_integrity_o)
  );

  sl_req_attribute_fifo #(.ATTR_WIDTH(1), .DEPTH(ATTR_FIFO_DEPTH)) u_data_gntpar_fifo (
    .in_support_if(in_support_if),
    .reset_i      (reset_i),
    .req_i        (data_req_i),
    .gnt_i        (data_gnt_i),
    .rvalid_i     (data_rvalid_i),
    .attr_i       (data_gntpar_err),
    .attr_o       (gntpar_error_in_response_data_o)
  );

  // --------------------
  // core trackers
  // --------------------
  sl_exception_tracker u_exc_tracker (
    .in_support_if        (in_support_if),
    .reset_i              (reset_i),
    .pc_set_i             (pc_set_i),
    .pc_mux_i             (pc_mux_i),
    .rvfi_valid_i         (rvfi_valid_i),
    .data_req_i           (data_req_i),
    .data_gnt_i           (data_gnt_i),
    .req_after_exception_o(req_after_exception_o)
  );

  sl_debug_tracker u_dbg_tracker (
    .in_support_if     (in_support_if),
    .reset_i           (reset_i),
    .rvfi_valid_i      (rvfi_valid_i),
    .rvfi_dbg_mode_i   (rvfi_dbg_mode_i),
    .rvfi_is_dret_i    (rvfi_is_dret_i),
    .rvfi_trap_i       (rvfi_trap_i),
    .debug_req_i       (debug_req_i),
    .fetch_enable_i    (fetch_enable_i),
    .first_debug_ins_o (first_debug_ins_o),
    .first_fetch_o     (first_fetch_o),
    .recorded_dbg_req_o(recorded_dbg_req_o)
  );

endmodule : sl_support_logic

/* verification/tb_sl_support_logic.sv */
// testbench for the support logic top: table-driven bus, trap and debug checks
`timescale 1ns/10ps

module tb_sl_support_logic
  import sl_ctrl_pkg::*;
  import sl_obi_pkg::*;
;

  localparam int CNT_W        = OBI_CNT_W_C;
  localparam int RESET_CYCLES = 2;

  // one row is one clock cycle of stimulus and the outputs expected in it
  typedef struct {
    string            name;
    logic [10:0]      stim;
    pc_mux_e          mux;
    logic [5:0]       core;
    logic [12:0]      flags;
    logic [CNT_W-1:0] icnt;
    logic [CNT_W-1:0] dcnt;
  } row_t;

  logic in_support_if, reset_i;
  logic instr_req_i, instr_gnt_i, instr_gntpar_i, instr_rvalid_i, instr_integrity_i;
  logic [31:0] instr_req_pc_i;
  logic data_req_i, data_gnt_i, data_gntpar_i, data_rvalid_i;
  logic data_req_is_store_i, data_integrity_i;
  logic pc_set_i;
  pc_mux_e pc_mux_i;
  logic rvfi_valid_i, rvfi_dbg_mode_i, rvfi_is_dret_i, rvfi_trap_i;
  logic debug_req_i, fetch_enable_i;
  logic instr_addr_ph_cont_o, instr_resp_ph_cont_o;
  logic [CNT_W-1:0] instr_v_addr_ph_cnt_o;
  logic [31:0] instr_resp_pc_o;
  logic instr_req_had_integrity_o, gntpar_error_in_response_instr_o;
  logic data_addr_ph_cont_o, data_resp_ph_cont_o;
  logic [CNT_W-1:0] data_v_addr_ph_cnt_o;
  logic req_was_store_o, data_req_had_integrity_o, gntpar_error_in_response_data_o;
  logic req_after_exception_o, first_debug_ins_o, first_fetch_o, recorded_dbg_req_o;

  row_t        rows[$];
  logic [31:0] pc_model[$];
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  // flag names by bit position, bit 0 first
  string flag_name [13] = '{"recorded_dbg_req", "first_fetch", "first_debug_ins",
    "req_after_exception", "data_gntpar_err", "data_integrity", "req_was_store",
    "data_resp_ph_cont", "data_addr_ph_cont", "instr_gntpar_err", "instr_integrity",
    "instr_resp_ph_cont", "instr_addr_ph_cont"};

  sl_support_logic #(.CNT_W(CNT_W), .ATTR_FIFO_DEPTH(ATTR_FIFO_DEPTH_C)) dut0 (.*);

  initial begin
    in_support_if = 1'b0;
    forever #50 in_support_if = ~in_support_if;
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s expected %0b actual %0b", what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cnt(input string what, input logic [CNT_W-1:0] exp,
                           input logic [CNT_W-1:0] act);
    if (act !== exp) begin
      $display("mismatch %s expected %0d actual %0d", what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_pc(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("mismatch %s expected %08h actual %08h", what, exp, act);
      err_cnt++;
    end
  endtask

  // --------------------
  // stimulus table
  // --------------------
  task automatic add_row(input string name, input logic [10:0] stim, input pc_mux_e mux,
                         input logic [5:0] core, input logic [12:0] flags,
                         input int icnt, input int dcnt);
    row_t r;
    r.name  = name;
    r.stim  = stim;
    r.mux   = mux;
    r.core  = core;
    r.flags = flags;
    r.icnt  = CNT_W'(icnt);
    r.dcnt  = CNT_W'(dcnt);
    rows.push_back(r);
  endtask

  // stim: instr {req gnt gntpar rvalid integ} _ data {req gnt gntpar rvalid store integ}
  // core: {rvfi valid dbg_mode is_dret trap} _ {debug_req fetch_enable}
  // flags: instr {addr resp integ gperr} _ data {addr resp store integ gperr} _
  //        {req_after_exc first_dbg first_fetch recorded}
  // a PC_BOOT mux means pc_set stays low
  task automatic build_table();
    // data bus stall, response phase and grant count
    add_row("ph_d_stall0", 11'b00100_101011, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 0, 0);
    add_row("ph_d_stall1", 11'b00100_101011, PC_BOOT, 6'b0000_00, 13'b0000_10000_0000, 0, 0);
    add_row("ph_d_grant", 11'b00100_110011, PC_BOOT, 6'b0000_00, 13'b0000_10000_0000, 0, 0);
    add_row("ph_d_wait", 11'b00100_001000, PC_BOOT, 6'b0000_00, 13'b0000_01110_0000, 0, 1);
    add_row("ph_d_resp", 11'b00100_001100, PC_BOOT, 6'b0000_00, 13'b0000_00110_0000, 0, 1);
    add_row("ph_d_idle", 11'b00100_001000, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 0, 1);
    // three back-to-back fetches, pc checked against the model queue
    add_row("pc_req0", 11'b11001_001000, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 0, 1);
    add_row("pc_req1", 11'b11000_001000, PC_BOOT, 6'b0000_00, 13'b0110_00000_0000, 1, 1);
    add_row("pc_req2", 11'b11011_001000, PC_BOOT, 6'b0000_00, 13'b0010_00000_0000, 2, 1);
    add_row("pc_resp1", 11'b00110_001000, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 3, 1);
    add_row("pc_wait2", 11'b00100_001000, PC_BOOT, 6'b0000_00, 13'b0110_00000_0000, 3, 1);
    add_row("pc_resp2", 11'b00110_001000, PC_BOOT, 6'b0000_00, 13'b0010_00000_0000, 3, 1);
    add_row("pc_empty", 11'b00100_001000, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 3, 1);
    // bad parity early in a stall survives to the response
    add_row("gp_bad", 11'b00100_100000, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 3, 1);
    add_row("gp_stall", 11'b00100_101000, PC_BOOT, 6'b0000_00, 13'b0000_10000_0000, 3, 1);
    add_row("gp_grant", 11'b00100_110000, PC_BOOT, 6'b0000_00, 13'b0000_10000_0000, 3, 1);
    add_row("gp_resp", 11'b00100_001100, PC_BOOT, 6'b0000_00, 13'b0000_00001_0000, 3, 2);
    // trap with a data request after a grant, then a retire
    add_row("exc_gnt", 11'b00100_110000, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 3, 2);
    add_row("exc_trap", 11'b00100_101100, PC_TRAP_EXC, 6'b0000_00, 13'b0000_00000_0000, 3, 3);
    add_row("exc_set", 11'b00100_110000, PC_BOOT, 6'b0000_00, 13'b0000_10000_1000, 3, 3);
    add_row("exc_retire", 11'b00100_001100, PC_BOOT, 6'b1000_00, 13'b0000_00000_1000, 3, 4);
    add_row("exc_clear", 11'b00100_001000, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 3, 4);
    // same pattern with a jump never flags
    add_row("jmp_gnt", 11'b00100_110000, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 3, 4);
    add_row("jmp_set", 11'b00100_101100, PC_JUMP, 6'b0000_00, 13'b0000_00000_0000, 3, 5);
    add_row("jmp_grant", 11'b00100_110000, PC_BOOT, 6'b0000_00, 13'b0000_10000_0000, 3, 5);
    add_row("jmp_resp", 11'b00100_001100, PC_BOOT, 6'b0000_00, 13'b0000_00000_0000, 3, 6);
    // startup, debug entry, dret rearm and request recording
    add_row("fetch_first", 11'b00100_001000, PC_BOOT, 6'b0000_01, 13'b0000_00000_0010, 3, 6);
    add_row("fetch_again", 11'b00100_001000, PC_BOOT, 6'b0000_01, 13'b0000_00000_0000, 3, 6);
    add_row("dbg_req", 11'b00100_001000, PC_BOOT, 6'b0000_11, 13'b0000_00000_0000, 3, 6);
    add_row("dbg_ret_dm", 11'b00100_001000, PC_BOOT, 6'b1100_01, 13'b0000_00000_0101, 3, 6);
    add_row("dbg_ret_dm2", 11'b00100_001000, PC_BOOT, 6'b1100_01, 13'b0000_00000_0001, 3, 6);
    add_row("dbg_dret", 11'b00100_001000, PC_BOOT, 6'b1110_01, 13'b0000_00000_0001, 3, 6);
    add_row("dbg_aft_dret", 11'b00100_001000, PC_BOOT, 6'b0000_01, 13'b0000_00000_0000, 3, 6);
    add_row("dbg_reentry", 11'b00100_001000, PC_BOOT, 6'b1100_01, 13'b0000_00000_0100, 3, 6);
    add_row("dbg_trap_drt", 11'b00100_001000, PC_BOOT, 6'b1111_01, 13'b0000_00000_0000, 3, 6);
    add_row("dbg_no_rearm", 11'b00100_001000, PC_BOOT, 6'b1100_01, 13'b0000_00000_0000, 3, 6);
    add_row("dbg_exit", 11'b00100_001000, PC_BOOT, 6'b1000_01, 13'b0000_00000_0000, 3, 6);
    add_row("dbg_req_ret", 11'b00100_001000, PC_BOOT, 6'b1000_11, 13'b0000_00000_0000, 3, 6);
    add_row("rec_hold", 11'b00100_001000, PC_BOOT, 6'b1000_01, 13'b0000_00000_0001, 3, 6);
    add_row("rec_hold2", 11'b00100_001000, PC_BOOT, 6'b1000_01, 13'b0000_00000_0001, 3, 6);
    add_row("rec_clear", 11'b00100_001000, PC_BOOT, 6'b0000_01, 13'b0000_00000_0000, 3, 6);
  endtask

  task automatic drive_row(input row_t r);
    {instr_req_i, instr_gnt_i, instr_gntpar_i, instr_rvalid_i, instr_integrity_i} = r.stim[10:6];
    {data_req_i, data_gnt_i, data_gntpar_i, data_rvalid_i} = r.stim[5:2];
    {data_req_is_store_i, data_integrity_i} = r.stim[1:0];
    pc_set_i = (r.mux != PC_BOOT);
    pc_mux_i = r.mux;
    {rvfi_valid_i, rvfi_dbg_mode_i, rvfi_is_dret_i, rvfi_trap_i} = r.core[5:2];
    {debug_req_i, fetch_enable_i} = r.core[1:0];
    instr_req_pc_i = $urandom;
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin : main
    row_t        r;
    logic [12:0] act;
    logic [31:0] exp_pc;
    int          err_before;
    void'($urandom(32'h28bb_7e8a));
    build_table();
    reset_i = 1'b1;
    {instr_req_i, instr_gnt_i, instr_gntpar_i, instr_rvalid_i, instr_integrity_i} = 5'b00100;
    {data_req_i, data_gnt_i, data_gntpar_i, data_rvalid_i} = 4'b0010;
    {data_req_is_store_i, data_integrity_i} = 2'b00;
    instr_req_pc_i = 32'h0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    {rvfi_valid_i, rvfi_dbg_mode_i, rvfi_is_dret_i, rvfi_trap_i} = 4'b0000;
    {debug_req_i, fetch_enable_i} = 2'b00;
    repeat (RESET_CYCLES) @(posedge in_support_if);
    foreach (rows[i]) begin
      r = rows[i];
      @(negedge in_support_if);
      reset_i = 1'b0;
      drive_row(r);
      // settle well before the next rising edge
      #10;
      err_before = err_cnt;
      act = {instr_addr_ph_cont_o, instr_resp_ph_cont_o, instr_req_had_integrity_o,
             gntpar_error_in_response_instr_o, data_addr_ph_cont_o, data_resp_ph_cont_o,
             req_was_store_o, data_req_had_integrity_o, gntpar_error_in_response_data_o,
             req_after_exception_o, first_debug_ins_o, first_fetch_o, recorded_dbg_req_o};
      for (int b = 12; b >= 0; b--) begin
        check_flag({r.name, ".", flag_name[b]}, r.flags[b], act[b]);
      end
      check_cnt({r.name, ".instr_cnt"}, r.icnt, instr_v_addr_ph_cnt_o);
      check_cnt({r.name, ".data_cnt"}, r.dcnt, data_v_addr_ph_cnt_o);
      // oldest granted fetch pc, zero with nothing outstanding
      exp_pc = (pc_model.size() == 0) ? 32'h0 : pc_model[0];
      check_pc({r.name, ".resp_pc"}, exp_pc, instr_resp_pc_o);
      if (instr_rvalid_i && (pc_model.size() != 0)) begin
        void'(pc_model.pop_front());
      end
      if (instr_req_i && instr_gnt_i) begin
        pc_model.push_back(instr_req_pc_i);
      end
      if (err_cnt == err_before) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      $display("%-14s %-12s %s", r.name, pc_mux_i.name(),
               (err_cnt == err_before) ? "ok" : "error");
    end
    $display("tests %0d, passed %0d, failed %0d", rows.size(), pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog sized from the table
  initial begin : watchdog
    @(posedge in_support_if);
    cycle_limit = rows.size() + RESET_CYCLES + 20;
    while (cycle_cnt < cycle_limit) begin
      @(posedge in_support_if);
      cycle_cnt++;
    end
    $display("error: run hung, cycle limit %0d reached", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule : tb_sl_support_logic

/* flist.f */
src/sl_ctrl_pkg.sv
src/sl_obi_pkg.sv
src/sl_obi_phases_monitor.sv
src/sl_req_attribute_fifo.sv
src/sl_gntpar_detector.sv
src/sl_exception_tracker.sv
src/sl_debug_tracker.sv
src/sl_support_logic.sv
verification/tb_sl_support_logic.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/10ps
TOP       := tb_sl_support_logic
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
